/* design/ps2_kbd_pkg.sv */
`default_nettype none

package ps2_kbd_pkg;

    typedef logic [7:0] scancode_t;
    typedef logic [6:0] ascii_t;
    typedef logic [3:0] nibble_t;

    // Active low, bit 0 is segment a, bit 7 the decimal point.
    typedef logic [7:0] seg_t;

    localparam seg_t SEG_GLYPHS [0:15] = '{
        8'hC0, 8'hF9, 8'hA4, 8'hB0,
        8'h99, 8'h92, 8'h82, 8'hF8,
        8'h80, 8'h90, 8'h88, 8'h83,
        8'hC6, 8'hA1, 8'h86, 8'h8E
    };

    localparam seg_t SEG_BLANK = 8'hFF;

    localparam scancode_t BREAK_CODE = 8'hF0;
    localparam scancode_t EXT_CODE   = 8'hE0;

    localparam int DIGIT_COUNT = 4;

    typedef enum logic [2:0] {
        IDLE,
        FETCH,
        DECODE,
        WAIT_BREAK,
        RELEASE
    } track_state_t;

endpackage

`default_nettype wire

/* design/ps2_rx_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface ps2_rx_if;
    import ps2_kbd_pkg::*;

    scancode_t data;
    logic      ready;
    logic      overflow;
    logic      next_n;

    modport source (
        output data,
        output ready,
        output overflow,
        input  next_n
    );

    modport sink (
        input  data,
        input  ready,
        input  overflow,
        output next_n
    );

endinterface

`default_nettype wire

/* design/seg7_digit.sv */
`timescale 1ns/1ps
`default_nettype none

module seg7_digit (
    input  ps2_kbd_pkg::nibble_t value,
    input  logic                 blank,
    output ps2_kbd_pkg::seg_t    seg
);
    import ps2_kbd_pkg::*;

    always_comb
    begin
        if (blank)
        begin
            seg = SEG_BLANK;
        end
        else
        begin
            seg = SEG_GLYPHS[value];
        end
    end

endmodule

`default_nettype wire

/* design/scancode_rom.sv */
`timescale 1ns/1ps
`default_nettype none

module scancode_rom (
    input  logic                   clk,
    input  ps2_kbd_pkg::scancode_t code,
    output ps2_kbd_pkg::ascii_t    ascii
);
    import ps2_kbd_pkg::*;

    always_ff @(posedge clk)
    begin
        case (code)
            // Letters, lower case.
            8'h1C: ascii <= 7'h61;
            8'h32: ascii <= 7'h62;
            8'h21: ascii <= 7'h63;
            8'h23: ascii <= 7'h64;
            8'h24: ascii <= 7'h65;
            8'h2B: ascii <= 7'h66;
            8'h34: ascii <= 7'h67;
            8'h33: ascii <= 7'h68;
            8'h43: ascii <= 7'h69;
            8'h3B: ascii <= 7'h6A;
            8'h42: ascii <= 7'h6B;
            8'h4B: ascii <= 7'h6C;
            8'h3A: ascii <= 7'h6D;
            8'h31: ascii <= 7'h6E;
            8'h44: ascii <= 7'h6F;
            8'h4D: ascii <= 7'h70;
            8'h15: ascii <= 7'h71;
            8'h2D: ascii <= 7'h72;
            8'h1B: ascii <= 7'h73;
            8'h2C: ascii <= 7'h74;
            8'h3C: ascii <= 7'h75;
            8'h2A: ascii <= 7'h76;
            8'h1D: ascii <= 7'h77;
            8'h22: ascii <= 7'h78;
            8'h35: ascii <= 7'h79;
            8'h1A: ascii <= 7'h7A;
            // Top-row digits.
            8'h45: ascii <= 7'h30;
            8'h16: ascii <= 7'h31;
            8'h1E: ascii <= 7'h32;
            8'h26: ascii <= 7'h33;
            8'h25: ascii <= 7'h34;
            8'h2E: ascii <= 7'h35;
            8'h36: ascii <= 7'h36;
            8'h3D: ascii <= 7'h37;
            8'h3E: ascii <= 7'h38;
            8'h46: ascii <= 7'h39;
            default: ascii <= '0;
        endcase
    end

endmodule

`default_nettype wire

/* design/ps2_receiver.sv */
`timescale 1ns/1ps
`default_nettype none

module ps2_receiver #(
    parameter int FIFO_DEPTH = 8
) (
    input  logic          clk,
    input  logic          rst,
    input  logic          ps2_clk,
    input  logic          ps2_dat,
    ps2_rx_if.source      rx
);
    import ps2_kbd_pkg::*;

    localparam int PTR_W = $clog2(FIFO_DEPTH);

    logic             clk_meta;
    logic             clk_sync;
    logic             clk_prev;
    logic             dat_meta;
    logic             dat_sync;
    logic             fall;

    logic [3:0]       bit_cnt;
    logic [9:0]       frame_q;
    logic             frame_ok;
    logic             wr_pend;
    scancode_t        wr_byte;

    scancode_t        fifo_mem [FIFO_DEPTH];
    logic [PTR_W:0]   w_ptr;
    logic [PTR_W:0]   r_ptr;
    logic             empty;
    logic             full;
    logic             pop;
    logic             push;
    logic             overflow_q;

    // Both lines idle high.
    always_ff @(posedge clk)
    begin
        if (!rst)
        begin
            clk_meta <= 1'b1;
            clk_sync <= 1'b1;
            clk_prev <= 1'b1;
            dat_meta <= 1'b1;
            dat_sync <= 1'b1;
        end
        else
        begin
            clk_meta <= ps2_clk;
            clk_sync <= clk_meta;
            clk_prev <= clk_sync;
            dat_meta <= ps2_dat;
            dat_sync <= dat_meta;
        end
    end

    assign fall = clk_prev & ~clk_sync;

    // Start bit at bit 0, data in 8:1, parity at bit 9; stop bit is the live sample.
    assign frame_ok = (frame_q[0] == 1'b0) && (^frame_q[9:1]) && dat_sync;

    always_ff @(posedge clk)
    begin
        if (!rst)
        begin
            bit_cnt <= 4'd0;
            wr_pend <= 1'b0;
        end
        else
        begin
            wr_pend <= 1'b0;
            if (fall)
            begin
                if (bit_cnt == 4'd10)
                begin
                    bit_cnt <= 4'd0;
                    wr_pend <= frame_ok;
                end
                else
                begin
                    bit_cnt <= bit_cnt + 4'd1;
                end
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (fall)
        begin
            if (bit_cnt == 4'd10)
            begin
                wr_byte <= frame_q[8:1];
            end
            else
            begin
                frame_q <= {dat_sync, frame_q[9:1]};
            end
        end
    end

    assign empty = (w_ptr == r_ptr);
    assign full  = (w_ptr[PTR_W] != r_ptr[PTR_W]) &&
                   (w_ptr[PTR_W-1:0] == r_ptr[PTR_W-1:0]);
    assign pop   = !rx.next_n && !empty;
    // A pop in the same cycle frees the slot for the incoming byte.
    assign push  = wr_pend && (!full || pop);

    always_ff @(posedge clk)
    begin
        if (!rst)
        begin
            w_ptr      <= '0;
            r_ptr      <= '0;
            overflow_q <= 1'b0;
        end
        else
        begin
            if (pop)
            begin
                r_ptr      <= r_ptr + 1'b1;
                overflow_q <= 1'b0;
            end
            if (push)
            begin
                w_ptr <= w_ptr + 1'b1;
            end
            else if (wr_pend)
            begin
                overflow_q <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (push)
        begin
            fifo_mem[w_ptr[PTR_W-1:0]] <= wr_byte;
        end
    end

    assign rx.data     = fifo_mem[r_ptr[PTR_W-1:0]];
    assign rx.ready    = !empty;
    assign rx.overflow = overflow_q;

endmodule

`default_nettype wire

/* design/scancode_tracker.sv */
`timescale 1ns/1ps
`default_nettype none

module scancode_tracker (
    input  logic                   clk,
    input  logic                   rst,
    ps2_rx_if.sink                 rx,
    output ps2_kbd_pkg::scancode_t key_code,
    output logic                   blank
);
    import ps2_kbd_pkg::*;

    track_state_t state;
    scancode_t    byte_q;
    logic         next_n_q;

    always_ff @(posedge clk)
    begin
        if (!rst)
        begin
            state    <= IDLE;
            next_n_q <= 1'b1;
            key_code <= '0;
            blank    <= 1'b1;
        end
        else
        begin
            next_n_q <= 1'b1;
            case (state)
                IDLE:
                begin
                    if (rx.ready && !rx.overflow)
                    begin
                        state <= FETCH;
                    end
                end
                FETCH:
                begin
                    // The pop pulse lands in the next state.
                    next_n_q <= 1'b0;
                    if (rx.data == BREAK_CODE)
                    begin
                        state <= WAIT_BREAK;
                    end
                    else
                    begin
                        state <= DECODE;
                    end
                end
                DECODE:
                begin
                    if (byte_q != EXT_CODE)
                    begin
                        key_code <= byte_q;
                        blank    <= 1'b0;
                    end
                    state <= IDLE;
                end
                WAIT_BREAK:
                begin
                    // First cycle pops F0, so the FIFO outputs are stale until then.
                    if (next_n_q && rx.ready && !rx.overflow)
                    begin
                        next_n_q <= 1'b0;
                        state    <= RELEASE;
                    end
                end
                RELEASE:
                begin
                    blank <= 1'b1;
                    state <= IDLE;
                end
                default:
                begin
                    state <= IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (state == FETCH)
        begin
            byte_q <= rx.data;
        end
    end

    assign rx.next_n = next_n_q;

endmodule

`default_nettype wire

/* design/ps2_display_top.sv */
`timescale 1ns/1ps
`default_nettype none

module ps2_display_top #(
    parameter int FIFO_DEPTH = 8
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              ps2_clk,
    input  logic              ps2_dat,
    output ps2_kbd_pkg::seg_t seg1,
    output ps2_kbd_pkg::seg_t seg2,
    output ps2_kbd_pkg::seg_t seg3,
    output ps2_kbd_pkg::seg_t seg4
);
    import ps2_kbd_pkg::*;

    scancode_t key_code;
    logic      blank;
    ascii_t    ascii;
    ascii_t    ascii_ones;
    ascii_t    ascii_tens;

    nibble_t   digit_val   [DIGIT_COUNT];
    logic      digit_blank [DIGIT_COUNT];
    seg_t      digit_seg   [DIGIT_COUNT];

    ps2_rx_if rx_if ();

    ps2_receiver #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) receiver_i (
        .clk     (clk),
        .rst     (rst),
        .ps2_clk (ps2_clk),
        .ps2_dat (ps2_dat),
        .rx      (rx_if.source)
    );

    scancode_tracker tracker_i (
        .clk      (clk),
        .rst      (rst),
        .rx       (rx_if.sink),
        .key_code (key_code),
        .blank    (blank)
    );

    scancode_rom rom_i (
        .clk   (clk),
        .code  (key_code),
        .ascii (ascii)
    );

    // Tens reach 12 for 'x' to 'z' and show as a hex glyph.
    assign ascii_ones = ascii % ascii_t'(10);
    assign ascii_tens = ascii / ascii_t'(10);

    assign digit_val[0]   = key_code[3:0];
    assign digit_val[1]   = key_code[7:4];
    assign digit_val[2]   = ascii_ones[3:0];
    assign digit_val[3]   = ascii_tens[3:0];

    assign digit_blank[0] = blank;
    assign digit_blank[1] = blank;
    assign digit_blank[2] = 1'b0;
    assign digit_blank[3] = 1'b0;

    for (genvar i = 0; i < DIGIT_COUNT; i++)
    begin : g_digit
        seg7_digit digit_i (
            .value (digit_val[i]),
            .blank (digit_blank[i]),
            .seg   (digit_seg[i])
        );
    end

    assign seg1 = digit_seg[0];
    assign seg2 = digit_seg[1];
    assign seg3 = digit_seg[2];
    assign seg4 = digit_seg[3];

endmodule

`default_nettype wire

/* verification/ps2_display_clkgen.sv */
`timescale 1ns/1ps
`default_nettype none

module ps2_display_clkgen #(
    parameter int PERIOD_NS    = 8,
    parameter int RESET_CYCLES = 8
) (
    output logic clk,
    output logic rst
);

    initial
    begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    // Reset is active low and released on a falling edge.
    initial
    begin
        rst = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst = 1'b1;
    end

endmodule

`default_nettype wire

/* verification/ps2_display_sva.sv */
`timescale 1ns/1ps
`default_nettype none

module ps2_display_sva (
    input logic                   clk,
    input logic                   rst,
    input logic                   next_n,
    input logic                   ready,
    input ps2_kbd_pkg::scancode_t data,
    input logic                   blank
);
    import ps2_kbd_pkg::*;

    // A pop is a single low clock of next_n.
    pop_one_clock: assert property (
        @(posedge clk) disable iff (!rst) !next_n |=> next_n
    ) else $error("next_n held low for more than one clock");

    pop_needs_data: assert property (
        @(posedge clk) disable iff (!rst) !next_n |-> ready
    ) else $error("pop issued while the FIFO is empty");

    // Blank only drops on the clock after a make code is popped.
    blank_drops_on_make: assert property (
        @(posedge clk) disable iff (!rst)
        $fell(blank) |-> $past(!next_n && data != BREAK_CODE && data != EXT_CODE)
    ) else $error("blank dropped without a popped make code");

endmodule

bind scancode_tracker ps2_display_sva sva_i (
    .clk    (clk),
    .rst    (rst),
    .next_n (next_n_q),
    .ready  (rx.ready),
    .data   (rx.data),
    .blank  (blank)
);

`default_nettype wire

/* verification/ps2_display_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module ps2_display_tb;
    import ps2_kbd_pkg::*;

    localparam int FIFO_DEPTH   = 8;
    localparam int CLK_PERIOD   = 8;
    localparam int RESET_CLKS   = 8;
    localparam int PS2_HALF     = 16;
    localparam int SETTLE_CLKS  = 64;
    localparam int FRAME_CLKS   = 11 * 2 * PS2_HALF;
    localparam int RANDOM_TOTAL = 46;
    localparam int FRAME_COUNT  = RANDOM_TOTAL + 4 + 2 + 2 + FIFO_DEPTH + 1;
    localparam longint WATCHDOG_NS = longint'(FRAME_COUNT) *
                                     longint'(FRAME_CLKS + SETTLE_CLKS) * 2 * CLK_PERIOD;

    // Set-2 make codes, a to z and 0 to 9.
    localparam scancode_t LETTER_CODES [26] = '{
        8'h1C, 8'h32, 8'h21, 8'h23, 8'h24, 8'h2B, 8'h34, 8'h33, 8'h43,
        8'h3B, 8'h42, 8'h4B, 8'h3A, 8'h31, 8'h44, 8'h4D, 8'h15, 8'h2D,
        8'h1B, 8'h2C, 8'h3C, 8'h2A, 8'h1D, 8'h22, 8'h35, 8'h1A
    };
    localparam scancode_t DIGIT_CODES [10] = '{
        8'h45, 8'h16, 8'h1E, 8'h26, 8'h25, 8'h2E, 8'h36, 8'h3D, 8'h3E, 8'h46
    };

    logic      clk;
    logic      rst;
    logic      ps2_clk;
    logic      ps2_dat;
    seg_t      seg1;
    seg_t      seg2;
    seg_t      seg3;
    seg_t      seg4;

    scancode_t exp_code;
    logic      exp_blank;
    ascii_t    exp_ascii;
    logic      break_pend;
    scancode_t stim_code;
    int        errors;
    int        checks;
    int        tests_run;
    int        tests_failed;
    int        test_err_base;

    ps2_display_clkgen #(
        .PERIOD_NS    (CLK_PERIOD),
        .RESET_CYCLES (RESET_CLKS)
    ) clkgen_i (
        .clk (clk),
        .rst (rst)
    );

    ps2_display_top #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) dut_i (
        .clk     (clk),
        .rst     (rst),
        .ps2_clk (ps2_clk),
        .ps2_dat (ps2_dat),
        .seg1    (seg1),
        .seg2    (seg2),
        .seg3    (seg3),
        .seg4    (seg4)
    );

    function automatic ascii_t lookup_ascii(input scancode_t c);
        for (int i = 0; i < 26; i++)
        begin
            if (LETTER_CODES[i] == c)
                return ascii_t'(8'h61 + i);
        end
        for (int i = 0; i < 10; i++)
        begin
            if (DIGIT_CODES[i] == c)
                return ascii_t'(8'h30 + i);
        end
        return '0;
    endfunction

    function automatic scancode_t pick_table_code();
        int idx;
        idx = int'($urandom_range(35, 0));
        if (idx < 26)
            return LETTER_CODES[idx];
        return DIGIT_CODES[idx - 26];
    endfunction

    // A table code that differs from the one on display.
    function automatic scancode_t pick_new_table_code();
        scancode_t c;
        c = pick_table_code();
        while (c == exp_code)
        begin
            c = pick_table_code();
        end
        return c;
    endfunction

    function automatic scancode_t pick_other_code();
        scancode_t c;
        c = scancode_t'($urandom());
        while (lookup_ascii(c) != '0 || c == BREAK_CODE || c == EXT_CODE)
        begin
            c = scancode_t'($urandom());
        end
        return c;
    endfunction

    // Reference model of the make/break rules.
    function automatic void model_byte(input scancode_t b);
        if (break_pend)
        begin
            break_pend = 1'b0;
            exp_blank  = 1'b1;
        end
        else if (b == BREAK_CODE)
        begin
            break_pend = 1'b1;
        end
        else if (b != EXT_CODE)
        begin
            exp_code  = b;
            exp_blank = 1'b0;
            exp_ascii = lookup_ascii(b);
        end
    endfunction

    // Start, eight data bits LSB first, parity, stop.
    task automatic send_frame(input scancode_t b, input logic parity_ok, input logic stop_bit);
        logic [10:0] bits;
        logic        parity;
        parity = ~^b;
        if (!parity_ok)
            parity = ~parity;
        bits = {stop_bit, parity, b, 1'b0};
        @(negedge clk);
        for (int i = 0; i < 11; i++)
        begin
            ps2_dat = bits[i];
            repeat (PS2_HALF) @(negedge clk);
            ps2_clk = 1'b0;
            repeat (PS2_HALF) @(negedge clk);
            ps2_clk = 1'b1;
        end
        ps2_dat = 1'b1;
    endtask

    task automatic send_byte(input scancode_t b);
        send_frame(b, 1'b1, 1'b1);
        model_byte(b);
    endtask

    task automatic settle();
        repeat (SETTLE_CLKS) @(negedge clk);
    endtask

    task automatic check_seg(input string name, input seg_t expected, input seg_t actual);
        checks++;
        if (actual !== expected)
        begin
            errors++;
            $display("CHECK FAILED t=%0t %s expected %h got %h", $time, name, expected, actual);
        end
    endtask

    task automatic check_code_digits(input scancode_t c, input logic blank_exp);
        check_seg("seg1", blank_exp ? SEG_BLANK : SEG_GLYPHS[c[3:0]], seg1);
        check_seg("seg2", blank_exp ? SEG_BLANK : SEG_GLYPHS[c[7:4]], seg2);
    endtask

    task automatic check_ascii_digits(input ascii_t a);
        nibble_t ones;
        nibble_t tens;
        ones = nibble_t'(a % 7'd10);
        tens = nibble_t'(a / 7'd10);
        check_seg("seg3", SEG_GLYPHS[ones], seg3);
        check_seg("seg4", SEG_GLYPHS[tens], seg4);
    endtask

    task automatic check_display();
        check_code_digits(exp_code, exp_blank);
        check_ascii_digits(exp_ascii);
    endtask

    task automatic finish_test(input string name);
        tests_run++;
        if (errors == test_err_base)
        begin
            $display("test %s: ok", name);
        end
        else
        begin
            tests_failed++;
            $display("test %s: %0d mismatches", name, errors - test_err_base);
        end
        test_err_base = errors;
    endtask

    initial
    begin
        #(WATCHDOG_NS);
        $display("Timeout: run still busy after %0d ns", WATCHDOG_NS);
        $display("TEST FAILED");
        $finish;
    end

    initial
    begin
        void'($urandom(19));
        ps2_clk       = 1'b1;
        ps2_dat       = 1'b1;
        exp_code      = '0;
        exp_blank     = 1'b1;
        exp_ascii     = '0;
        break_pend    = 1'b0;
        errors        = 0;
        checks        = 0;
        tests_run     = 0;
        tests_failed  = 0;
        test_err_base = 0;

        wait (rst === 1'b1);
        repeat (4) @(negedge clk);
        check_seg("seg1", SEG_BLANK, seg1);
        check_seg("seg2", SEG_BLANK, seg2);
        check_seg("seg3", SEG_GLYPHS[0], seg3);
        check_seg("seg4", SEG_GLYPHS[0], seg4);
        finish_test("reset");

        for (int i = 0; i < RANDOM_TOTAL; i++)
        begin
            if (i % 8 == 3)
                stim_code = pick_other_code();
            else
                stim_code = pick_table_code();
            send_byte(stim_code);
            settle();
            check_display();
        end
        finish_test("random make codes");

        stim_code = pick_new_table_code();
        send_byte(stim_code);
        settle();
        check_display();
        send_byte(BREAK_CODE);
        settle();
        check_display();
        send_byte(stim_code);
        settle();
        check_display();
        send_byte(pick_table_code());
        settle();
        check_display();
        finish_test("release");

        send_byte(EXT_CODE);
        settle();
        check_display();
        send_byte(pick_new_table_code());
        settle();
        check_display();
        finish_test("extended prefix");

        stim_code = pick_new_table_code();
        send_frame(stim_code, 1'b0, 1'b1);
        settle();
        check_display();
        send_frame(stim_code, 1'b1, 1'b0);
        settle();
        check_display();
        finish_test("framing errors");

        stim_code = pick_new_table_code();
        repeat (FIFO_DEPTH + 1) send_byte(stim_code);
        settle();
        check_display();
        finish_test("burst");

        $display("Summary: %0d tests run, %0d failed, %0d checks, %0d errors",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0)
            $display("TEST PASSED");
        else
            $display("TEST FAILED");
        $finish;
    end

endmodule

`default_nettype wire

/* ps2_display_top.f */
design/ps2_kbd_pkg.sv
design/ps2_rx_if.sv
design/seg7_digit.sv
design/scancode_rom.sv
design/ps2_receiver.sv
design/scancode_tracker.sv
design/ps2_display_top.sv
verification/ps2_display_clkgen.sv
verification/ps2_display_sva.sv
verification/ps2_display_tb.sv

/* Makefile */
# Verilator build and run of the PS/2 display testbench.

TOP := ps2_display_tb
LOG := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) \
		-f ps2_display_top.f -Mdir obj_dir
	./obj_dir/V$(TOP) | tee $(LOG)
	@if grep -q "TEST FAILED" $(LOG); then exit 1; fi
	@grep -q "TEST PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
